//--- Bender.yml
package:
  name: pipelined_cpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/stage_ifs.sv
      - verilog/fetch_stage.sv
      - verilog/register_file.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/io_regs.sv
      - verilog/cpu_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/cpu_checker.sv
      - sim/tb_cpu.sv

//--- project.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/stage_ifs.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/io_regs.sv
verilog/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

//--- sim/cpu_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_checker import cpu_pkg::*; (
  input  wire                         clk,
  input  wire                         reset,
  input  wire [`CPU_HEX_BITS-1:0]     hex,
  input  wire [`CPU_LEDR_BITS-1:0]    ledr
);

  logic [`CPU_HEX_BITS-1:0]  exp_hex [$];   // Expected changes, oldest first
  logic [`CPU_LEDR_BITS-1:0] exp_ledr [$];
  logic [`CPU_HEX_BITS-1:0]  last_hex;
  logic [`CPU_LEDR_BITS-1:0] last_ledr;
  logic started = 1'b0;                     // First sample out of reset taken
  int   hex_errors = 0;
  int   ledr_errors = 0;
  int   other_errors = 0;                   // Unexpected or missing changes

  function automatic void push_hex(input logic [`CPU_HEX_BITS-1:0] v);
    exp_hex.push_back(v);
  endfunction

  function automatic void push_ledr(input logic [`CPU_LEDR_BITS-1:0] v);
    exp_ledr.push_back(v);
  endfunction

  function automatic int pending();
    return exp_hex.size() + exp_ledr.size();
  endfunction

  function automatic int total_errors();
    return hex_errors + ledr_errors + other_errors;
  endfunction

  // Anything still queued never showed up at the ports
  function automatic void report_missing();
    if (pending() != 0)
    begin
      $display("%0d hex and %0d ledr values never appeared", exp_hex.size(), exp_ledr.size());
      other_errors += pending();
    end
  endfunction

  // Sampled at the edge, so the values are those before this edge's update
  always @(posedge clk)
  begin
    logic [`CPU_HEX_BITS-1:0]  want_hex;
    logic [`CPU_LEDR_BITS-1:0] want_ledr;
    if (reset)
      started = 1'b0;
    else if (!started)
    begin
      if (hex !== `CPU_HEX_RESET)   // Reset pattern before any store
      begin
        $display("error %0t ns: hex expected %06h, got %06h", $time, `CPU_HEX_RESET, hex);
        hex_errors++;
      end
      if (ledr !== '0)
      begin
        $display("error %0t ns: ledr expected %03h, got %03h", $time, 10'h0, ledr);
        ledr_errors++;
      end
      last_hex  = hex;
      last_ledr = ledr;
      started   = 1'b1;
    end
    else
    begin
      if (hex !== last_hex)
      begin
        if (exp_hex.size() == 0)
        begin
          $display("hex changed to %06h at %0t ns with nothing more expected", hex, $time);
          other_errors++;
        end
        else
        begin
          want_hex = exp_hex.pop_front();
          if (hex !== want_hex)
          begin
            $display("error %0t ns: hex expected %06h, got %06h", $time, want_hex, hex);
            hex_errors++;
          end
        end
        last_hex = hex;
      end
      if (ledr !== last_ledr)
      begin
        if (exp_ledr.size() == 0)
        begin
          $display("ledr changed to %03h at %0t ns with nothing more expected", ledr, $time);
          other_errors++;
        end
        else
        begin
          want_ledr = exp_ledr.pop_front();
          if (ledr !== want_ledr)
          begin
            $display("error %0t ns: ledr expected %03h, got %03h", $time, want_ledr, ledr);
            ledr_errors++;
          end
        end
        last_ledr = ledr;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module tb_cpu import cpu_pkg::*; ();

  localparam word_t HEX_ADDR  = `CPU_ADDR_HEX;
  localparam word_t LEDR_ADDR = `CPU_ADDR_LEDR;
  localparam word_t KEY_ADDR  = `CPU_ADDR_KEY;
  localparam word_t START_PC  = `CPU_START_PC;

  logic                           clk;
  logic                           reset;
  logic                           prog_we;
  logic [`CPU_IMEM_ADDR_BITS-1:0] prog_addr;
  word_t                          prog_data;
  logic [`CPU_KEY_BITS-1:0]       key;
  wire  [`CPU_HEX_BITS-1:0]       hex;
  wire  [`CPU_LEDR_BITS-1:0]      ledr;

  logic [31:0] lfsr;        // Stimulus generator state
  word_t       prog [$];    // Program image from START_PC on
  logic [3:0]  key_val;
  int          prog_len;
  logic        running = 1'b0;

  cpu_top i_cpu_top (
    .clk, .reset, .prog_we, .prog_addr, .prog_data, .key, .hex, .ledr
  );

  cpu_checker i_checker (.clk, .reset, .hex, .ledr);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 10 ns
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic regno_t src_reg();   // R1..R8
    return regno_t'(take_bits(3)) + 4'd1;
  endfunction

  function automatic regno_t dst_reg();   // R9..R15
    return regno_t'(4'd9 + take_bits(3) % 7);
  endfunction

  function automatic word_t enc_alur(input op2_e f, input regno_t rd, rs, rt);
    return {ALUR, f, 6'b0, rd, rs, rt};
  endfunction

  function automatic word_t enc_imm(input op1_e op, input logic [15:0] imm, input regno_t rs, rt);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  function automatic void emit(input word_t w);
    prog.push_back(w);
  endfunction

  // Register value out to both displays
  function automatic void show(input regno_t r);
    emit(enc_imm(SW, HEX_ADDR[15:0], 4'd0, r));
    emit(enc_imm(SW, LEDR_ADDR[15:0], 4'd0, r));
  endfunction

  function automatic void build_program();
    op2_e        alu_ops [0:13];
    op1_e        imm_ops [0:3];
    regno_t      rs;
    regno_t      rt;
    regno_t      rd;
    word_t       here;
    logic [15:0] daddr;
    alu_ops = '{EQ, LT, LE, NE, ADD, AND, OR, XOR, SUB, NAND, NOR, NXOR, RSHF, LSHF};
    imm_ops = '{ADDI, ANDI, ORI, XORI};
    for (int r = 1; r < 8; r++)   // Random seeds in R1..R7
    begin
      emit(enc_imm(ADDI, 16'(take_bits(16)), 4'd0, regno_t'(r)));
      show(regno_t'(r));
    end
    emit(enc_imm(ADDI, 16'(take_bits(5)), 4'd0, 4'd8));      // Small shift count
    show(4'd8);
    foreach (alu_ops[i])
    begin
      rs = src_reg();
      rt = (alu_ops[i] inside {RSHF, LSHF}) ? 4'd8 : src_reg();
      rd = dst_reg();
      emit(enc_alur(alu_ops[i], rd, rs, rt));
      show(rd);                                               // Dependent store
    end
    emit(enc_alur(ADD, 4'd9, 4'd1, 4'd2));                    // Back-to-back chain
    emit(enc_alur(SUB, 4'd10, 4'd9, 4'd3));
    emit(enc_alur(XOR, 4'd11, 4'd10, 4'd9));
    show(4'd11);
    foreach (imm_ops[i])
    begin
      rt = dst_reg();
      emit(enc_imm(imm_ops[i], 16'(take_bits(16)), src_reg(), rt));
      show(rt);
    end
    emit(enc_imm(ADDI, 16'h0BAD, 4'd0, 4'd11));              // Marker value
    emit(enc_imm(BEQ, 16'd2, 4'd1, 4'd1));                    // Taken, skips the marker
    show(4'd11);
    show(4'd2);
    emit(enc_imm(BNE, 16'd2, 4'd2, 4'd2));                    // Not taken
    show(4'd11);
    show(4'd3);
    emit(enc_imm(ADDI, 16'(take_bits(16)), 4'd0, 4'd12));
    emit(enc_imm(BLT, 16'd2, src_reg(), src_reg()));          // Random outcome
    show(4'd12);
    emit(enc_imm(ADDI, 16'(take_bits(16)), 4'd0, 4'd12));
    emit(enc_imm(BLE, 16'd2, src_reg(), src_reg()));
    show(4'd12);
    show(4'd4);
    here = START_PC + 4 * prog.size();
    emit(enc_imm(JAL, 16'((here + 12) >> 2), 4'd0, 4'd12));   // Jump over two stores
    show(4'd11);
    show(4'd12);                                              // Return address
    for (int k = 0; k < 2; k++)
    begin
      daddr = {4'b0, 10'(take_bits(10)), 2'b00};
      emit(enc_imm(SW, daddr, 4'd0, src_reg()));
      emit(enc_imm(LW, daddr, 4'd0, 4'd13));
      show(4'd13);
    end
    emit(enc_imm(LW, KEY_ADDR[15:0], 4'd0, 4'd14));
    show(4'd14);
    emit(enc_imm(BEQ, 16'hFFFF, 4'd0, 4'd0));                 // Spin here
  endfunction

  function automatic word_t alu_ref(input op2_e f, input word_t a, b);
    case (f)
      EQ:      return word_t'(a == b);
      LT:      return word_t'($signed(a) < $signed(b));
      LE:      return word_t'($signed(a) <= $signed(b));
      NE:      return word_t'(a != b);
      ADD:     return a + b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SUB:     return a - b;
      NAND:    return ~(a & b);
      NOR:     return ~(a | b);
      NXOR:    return ~(a ^ b);
      RSHF:    return $signed(a) >>> b;
      LSHF:    return a << b;
      default: return '0;
    endcase
  endfunction

  // Runs the program without timing and queues each visible display change
  function automatic void run_reference();
    word_t       regs [0:15];
    word_t       dmem [0:1023];
    word_t       pc;
    word_t       w;
    word_t       a;
    word_t       b;
    word_t       imm;
    word_t       addr;
    word_t       nxt;
    word_t       wv;
    regno_t      dst;
    op1_e        op;
    logic [23:0] hex_now;
    logic [9:0]  ledr_now;
    logic        done;
    logic        do_wr;
    foreach (regs[i])
      regs[i] = '0;
    foreach (dmem[i])
      dmem[i] = '0;
    pc       = START_PC;
    hex_now  = `CPU_HEX_RESET;
    ledr_now = '0;
    done     = 1'b0;
    for (int step = 0; step < 10000 && !done; step++)
    begin
      w     = prog[(pc - START_PC) >> 2];
      op    = op1_e'(w[31:26]);
      a     = regs[w[7:4]];
      b     = regs[w[3:0]];
      imm   = {{16{w[23]}}, w[23:8]};
      addr  = a + imm;
      nxt   = pc + 4;
      dst   = w[3:0];   // Rt unless ALUR
      do_wr = 1'b1;
      wv    = '0;
      case (op)
        ALUR:
        begin
          dst = w[11:8];
          wv  = alu_ref(op2_e'(w[25:18]), a, b);
        end
        ADDI: wv = a + imm;
        ANDI: wv = a & imm;
        ORI:  wv = a | imm;
        XORI: wv = a ^ imm;
        LW:
        begin
          if (addr[31:12] == 20'hFFFFF)
            wv = (addr == KEY_ADDR) ? {28'b0, ~key_val} : '0;
          else
            wv = dmem[addr[11:2]];
        end
        JAL:
        begin
          wv  = pc + 4;
          nxt = a + (imm << 2);
        end
        default:
        begin
          do_wr = 1'b0;
          if ((op == BEQ && a == b) || (op == BNE && a != b) ||
              (op == BLT && $signed(a) < $signed(b)) ||
              (op == BLE && $signed(a) <= $signed(b)))
            nxt = pc + 4 + (imm << 2);
          if (op == SW)
          begin
            if (addr == HEX_ADDR && b[23:0] != hex_now)
            begin
              hex_now = b[23:0];
              i_checker.push_hex(hex_now);
            end
            else if (addr == LEDR_ADDR && b[9:0] != ledr_now)
            begin
              ledr_now = b[9:0];
              i_checker.push_ledr(ledr_now);
            end
            else if (addr[31:12] != 20'hFFFFF)
              dmem[addr[11:2]] = b;
          end
        end
      endcase
      if (do_wr && dst != 0)
        regs[dst] = wv;
      done = (nxt == pc);   // Self loop ends the program
      pc   = nxt;
    end
  endfunction

  initial
  begin
    reset     <= 1'b1;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    key       <= '0;
    lfsr      = 32'h5415;
    build_program();
    prog_len = prog.size();
    for (int i = 0; i < 4; i++)
      emit('0);            // NOP padding past the spin loop
    key_val = 4'(take_bits(4));
    run_reference();
    @(posedge clk);
    key <= key_val;
    foreach (prog[i])       // Load while the core sits in reset
    begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= START_PC[`CPU_IMEM_ADDR_BITS+1:2] + i[`CPU_IMEM_ADDR_BITS-1:0];
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    reset   <= 1'b0;
    running = 1'b1;
    while (i_checker.pending() != 0)
      @(posedge clk);
    repeat (20) @(posedge clk);   // Catch stray changes
    $display("hex errors %0d, ledr errors %0d, other errors %0d",
             i_checker.hex_errors, i_checker.ledr_errors, i_checker.other_errors);
    if (i_checker.total_errors() == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog sized from the program length
  initial
  begin
    wait (running);
    repeat (prog_len * 8 + 100) @(posedge clk);
    $display("Timeout while waiting for the expected display changes");
    i_checker.report_missing();
    $display("hex errors %0d, ledr errors %0d, other errors %0d",
             i_checker.hex_errors, i_checker.ledr_errors, i_checker.other_errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define CPU_DATA_BITS      32
`define CPU_REGNO_BITS     4
`define CPU_IMM_BITS       16

// Word-index widths of the two memories
`define CPU_IMEM_ADDR_BITS 14
`define CPU_DMEM_ADDR_BITS 10

// First fetch address out of reset
`define CPU_START_PC       32'h0000_0100

// Memory-mapped I/O, all inside the top 4 KB page
`define CPU_ADDR_HEX       32'hFFFF_F000
`define CPU_ADDR_LEDR      32'hFFFF_F020
`define CPU_ADDR_KEY       32'hFFFF_F080

// Board I/O widths
`define CPU_HEX_BITS       24
`define CPU_LEDR_BITS      10
`define CPU_KEY_BITS       4

// HEX pattern until the first store
`define CPU_HEX_RESET      24'hFEDEAD

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_BITS-1:0]  word_t;   // Data and instruction word
  typedef logic [`CPU_REGNO_BITS-1:0] regno_t;  // R0..R15

  // Primary opcode in inst[31:26]
  typedef enum logic [5:0] {
    ALUR = 6'b000000,  // Register-register, function in op2
    BEQ  = 6'b001000,
    BLT  = 6'b001001,
    BLE  = 6'b001010,
    BNE  = 6'b001011,
    JAL  = 6'b001100,
    LW   = 6'b010010,
    SW   = 6'b011010,
    ADDI = 6'b100000,  // Immediate ops all have bit 5 set
    ANDI = 6'b100100,
    ORI  = 6'b100101,
    XORI = 6'b100110
  } op1_e;

  // ALU function for ALUR, inst[25:18]
  typedef enum logic [7:0] {
    EQ   = 8'b00001000,  // Compares give 0 or 1
    LT   = 8'b00001001,
    LE   = 8'b00001010,
    NE   = 8'b00001011,
    ADD  = 8'b00100000,
    AND  = 8'b00100100,
    OR   = 8'b00100101,
    XOR  = 8'b00100110,
    SUB  = 8'b00101000,
    NAND = 8'b00101100,
    NOR  = 8'b00101101,
    NXOR = 8'b00101110,
    RSHF = 8'b00110000,  // Arithmetic right shift
    LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    logic is_br;   // Conditional branch
    logic is_jmp;  // JAL
    logic rd_mem;  // LW
    logic wr_mem;  // SW
    logic wr_reg;  // Result goes to a register
  } ctrl_t;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           prog_we,
  input  wire [`CPU_IMEM_ADDR_BITS-1:0] prog_addr,
  input  wire [`CPU_DATA_BITS-1:0]      prog_data,
  input  wire [`CPU_KEY_BITS-1:0]       key,
  output wire [`CPU_HEX_BITS-1:0]       hex,
  output wire [`CPU_LEDR_BITS-1:0]      ledr
);

  word_t  fe_inst;
  word_t  fe_pc;
  logic   stall;
  logic   dec_flush;
  logic   ex_flush;
  logic   redirect;
  word_t  redirect_pc;
  regno_t rd_a;
  regno_t rd_b;
  word_t  val_a;
  word_t  val_b;
  regno_t ex_wregno;
  regno_t mem_wregno;
  logic   wb_we;
  regno_t wb_regno;
  word_t  wb_data;
  word_t  io_addr;
  word_t  io_wdata;
  logic   io_we;
  word_t  io_rdata;

  dx_if dx_bus ();  // Decode latch
  xm_if xm_bus ();  // Execute latch

  fetch_stage i_fetch_stage (
    .clk, .reset, .prog_we, .prog_addr, .prog_data,
    .stall, .flush_req (dec_flush || ex_flush),   // Either stage holding a redirect
    .redirect, .redirect_pc, .inst (fe_inst), .pc (fe_pc)
  );

  decode_stage i_decode_stage (
    .clk, .reset, .inst (fe_inst), .pc (fe_pc), .rd_a, .rd_b, .val_a, .val_b,
    .ex_wregno, .mem_wregno, .wb_regno, .stall, .flush_req (dec_flush), .dx (dx_bus)
  );

  register_file i_register_file (
    .clk, .reset, .rd_a, .rd_b, .val_a, .val_b, .wb_we, .wb_regno, .wb_data
  );

  execute_stage i_execute_stage (
    .clk, .reset, .dx (dx_bus), .xm (xm_bus),
    .redirect, .redirect_pc, .flush_req (ex_flush), .ex_wregno
  );

  memory_stage i_memory_stage (
    .clk, .reset, .xm (xm_bus), .io_addr, .io_wdata, .io_we, .io_rdata,
    .mem_wregno, .wb_we, .wb_regno, .wb_data
  );

  io_regs i_io_regs (
    .clk, .reset, .io_addr, .io_wdata, .io_we, .io_rdata, .key, .hex, .ledr
  );

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire word_t  inst,        // Fetch latch
  input  wire word_t  pc,          // One past inst
  output regno_t      rd_a,        // Register file read ports
  output regno_t      rd_b,
  input  wire word_t  val_a,
  input  wire word_t  val_b,
  input  wire regno_t ex_wregno,   // Execute latch destination
  input  wire regno_t mem_wregno,  // Memory latch destination
  input  wire regno_t wb_regno,    // Register being written now
  output logic        stall,
  output logic        flush_req,
  dx_if.decode        dx
);

  op1_e   op1;
  op2_e   op2;
  regno_t rs;
  regno_t rt;
  regno_t rd;
  logic [`CPU_IMM_BITS-1:0] imm_raw;
  word_t  imm_sx;
  ctrl_t  ctrl;
  regno_t wregno;
  logic   is_ext;   // ALUR with a real function
  logic   is_alui;
  logic   hit_rs;   // Source still pending in a later stage
  logic   hit_rt;
  logic [3:0] stall_cond;

  // Instruction fields
  assign op1     = op1_e'(inst[31:26]);
  assign op2     = op2_e'(inst[25:18]);
  assign imm_raw = inst[23:8];   // Overlaps op2 and rd
  assign rd      = inst[11:8];
  assign rs      = inst[7:4];
  assign rt      = inst[3:0];
  assign rd_a    = rs;
  assign rd_b    = rt;

  assign imm_sx = {{(`CPU_DATA_BITS-`CPU_IMM_BITS){imm_raw[`CPU_IMM_BITS-1]}}, imm_raw};

  always_comb
  begin
    ctrl.is_br  = (inst[31:28] == 4'b0010);  // BEQ..BNE
    ctrl.is_jmp = (op1 == JAL);
    ctrl.rd_mem = (op1 == LW);
    ctrl.wr_mem = (op1 == SW);
    ctrl.wr_reg = !ctrl.is_br && !ctrl.wr_mem;
  end

  // Rd for ALUR, nothing for branch or SW, Rt for the rest
  assign wregno = (op1 == ALUR) ? rd : (ctrl.is_br || ctrl.wr_mem) ? '0 : rt;

  assign is_ext  = (op1 == ALUR) && (op2 != 8'h00);
  assign is_alui = op1 inside {ADDI, ANDI, ORI, XORI};

  // R0 never blocks
  assign hit_rs = (rs != '0) && ((rs == dx.wregno) || (rs == ex_wregno) ||
                                 (rs == mem_wregno) || (rs == wb_regno));
  assign hit_rt = (rt != '0) && ((rt == dx.wregno) || (rt == ex_wregno) ||
                                 (rt == mem_wregno) || (rt == wb_regno));

  assign stall_cond[0] = is_ext && (hit_rs || hit_rt);       // Both sources read
  assign stall_cond[1] = ctrl.is_br && (hit_rs || hit_rt);   // Compare needs both
  assign stall_cond[2] = ctrl.wr_mem && (hit_rs || hit_rt);  // Base and store data
  assign stall_cond[3] = (ctrl.is_jmp || ctrl.rd_mem || is_alui) && hit_rs;  // Rs only
  assign stall = |stall_cond;

  assign flush_req = ctrl.is_br || ctrl.is_jmp;

  // A stalled cycle sends the all-zero bundle downstream
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      dx.op1    <= ALUR;
      dx.op2    <= op2_e'(8'h00);
      dx.ctrl   <= '0;
      dx.val_a  <= '0;
      dx.val_b  <= '0;
      dx.imm    <= '0;
      dx.pc     <= '0;
      dx.wregno <= '0;
    end
    else
    begin
      dx.op1    <= stall ? ALUR : op1;
      dx.op2    <= stall ? op2_e'(8'h00) : op2;
      dx.ctrl   <= stall ? '0 : ctrl;
      dx.val_a  <= stall ? '0 : val_a;
      dx.val_b  <= stall ? '0 : val_b;
      dx.imm    <= stall ? '0 : imm_sx;
      dx.pc     <= stall ? '0 : pc;
      dx.wregno <= stall ? '0 : wregno;
    end
  end

  // Only a live source register can hold decode
  a_stall_has_source: assert property (@(posedge clk) disable iff (reset)
    stall |-> (inst != '0) && ((rs != '0) || (rt != '0)));

  // Fetch keeps its word while decode is held
  a_stall_holds_inst: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable(inst));

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  wire    clk,
  input  wire    reset,
  dx_if.execute  dx,
  xm_if.execute  xm,
  output logic   redirect,     // Every branch and JAL resteers fetch
  output word_t  redirect_pc,
  output logic   flush_req,    // Kill the word fetched behind us
  output regno_t ex_wregno     // For the decode hazard check
);

  word_t alu_out;
  logic  br_taken;

  always_comb
  begin
    alu_out = '0;
    case (dx.op1)
      ALUR:
      begin
        case (dx.op2)
          EQ:      alu_out = word_t'(dx.val_a == dx.val_b);
          LT:      alu_out = word_t'($signed(dx.val_a) < $signed(dx.val_b));
          LE:      alu_out = word_t'($signed(dx.val_a) <= $signed(dx.val_b));
          NE:      alu_out = word_t'(dx.val_a != dx.val_b);
          ADD:     alu_out = dx.val_a + dx.val_b;
          AND:     alu_out = dx.val_a & dx.val_b;
          OR:      alu_out = dx.val_a | dx.val_b;
          XOR:     alu_out = dx.val_a ^ dx.val_b;
          SUB:     alu_out = dx.val_a - dx.val_b;
          NAND:    alu_out = ~(dx.val_a & dx.val_b);
          NOR:     alu_out = ~(dx.val_a | dx.val_b);
          NXOR:    alu_out = ~(dx.val_a ^ dx.val_b);
          RSHF:    alu_out = $signed(dx.val_a) >>> dx.val_b;  // Sign fill
          LSHF:    alu_out = dx.val_a << dx.val_b;
          default: alu_out = '0;                              // NOP lands here
        endcase
      end
      LW, SW, ADDI: alu_out = dx.val_a + dx.imm;  // Address or sum
      ANDI:         alu_out = dx.val_a & dx.imm;
      ORI:          alu_out = dx.val_a | dx.imm;
      XORI:         alu_out = dx.val_a ^ dx.imm;
      default:      alu_out = '0;
    endcase
  end

  // Signed compare for branches
  always_comb
  begin
    case (dx.op1)
      BEQ:     br_taken = (dx.val_a == dx.val_b);
      BLT:     br_taken = ($signed(dx.val_a) < $signed(dx.val_b));
      BLE:     br_taken = ($signed(dx.val_a) <= $signed(dx.val_b));
      BNE:     br_taken = (dx.val_a != dx.val_b);
      default: br_taken = 1'b0;
    endcase
  end

  // dx.pc is already PC+4, so an untaken branch resumes there
  always_comb
  begin
    if (dx.ctrl.is_jmp)
      redirect_pc = dx.val_a + (dx.imm << 2);
    else if (br_taken)
      redirect_pc = dx.pc + (dx.imm << 2);
    else
      redirect_pc = dx.pc;
  end

  assign redirect  = dx.ctrl.is_br || dx.ctrl.is_jmp;
  assign flush_req = dx.ctrl.is_br || dx.ctrl.is_jmp;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      xm.wregno <= '0;
      xm.rd_mem <= 1'b0;
      xm.wr_mem <= 1'b0;
      xm.wr_reg <= 1'b0;
    end
    else
    begin
      xm.wregno <= dx.wregno;
      xm.rd_mem <= dx.ctrl.rd_mem;
      xm.wr_mem <= dx.ctrl.wr_mem;
      xm.wr_reg <= dx.ctrl.wr_reg;
    end
  end

  always_ff @(posedge clk)
  begin
    xm.result    <= dx.ctrl.is_jmp ? dx.pc : alu_out;  // JAL links PC+4
    xm.store_val <= dx.val_b;
  end

  assign ex_wregno = xm.wregno;

  // Decode sets at most one of the two redirect kinds
  a_br_jmp_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(dx.ctrl.is_br && dx.ctrl.is_jmp));

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          prog_we,      // Program load, used during reset
  input  wire [`CPU_IMEM_ADDR_BITS-1:0] prog_addr,   // Word index
  input  wire word_t                   prog_data,
  input  wire                          stall,        // From decode hazard check
  input  wire                          flush_req,    // Branch or JAL in decode or execute
  input  wire                          redirect,
  input  wire word_t                   redirect_pc,
  output word_t                        inst,         // Fetch latch
  output word_t                        pc            // Fetch address, one past inst
);

  word_t imem [0:(1 << `CPU_IMEM_ADDR_BITS)-1];
  word_t imem_word;

  assign imem_word = imem[pc[`CPU_IMEM_ADDR_BITS+1:2]];  // Word aligned

  always_ff @(posedge clk)
  begin
    if (prog_we)
      imem[prog_addr] <= prog_data;
  end

  // Redirect wins over stall
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `CPU_START_PC;
    else if (redirect)
      pc <= redirect_pc;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      inst <= '0;         // NOP
    else if (stall)
      inst <= inst;       // Decode retries the same word
    else if (flush_req)
      inst <= '0;         // Bubble behind a branch or JAL
    else
      inst <= imem_word;
  end

endmodule

`default_nettype wire

//--- verilog/io_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module io_regs import cpu_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  wire word_t                 io_addr,
  input  wire word_t                 io_wdata,
  input  wire                        io_we,
  output word_t                      io_rdata,
  input  wire [`CPU_KEY_BITS-1:0]    key,      // Buttons, active low
  output logic [`CPU_HEX_BITS-1:0]   hex,
  output logic [`CPU_LEDR_BITS-1:0]  ledr
);

  // Only KEY is readable, pressed reads as 1
  assign io_rdata = (io_addr == `CPU_ADDR_KEY) ?
                    {{(`CPU_DATA_BITS-`CPU_KEY_BITS){1'b0}}, ~key} : '0;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hex  <= `CPU_HEX_RESET;
      ledr <= '0;
    end
    else if (io_we)
    begin
      if (io_addr == `CPU_ADDR_HEX)
        hex <= io_wdata[`CPU_HEX_BITS-1:0];    // Low bits only
      if (io_addr == `CPU_ADDR_LEDR)
        ledr <= io_wdata[`CPU_LEDR_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module memory_stage import cpu_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  xm_if.memory        xm,
  output word_t       io_addr,
  output word_t       io_wdata,
  output logic        io_we,
  input  wire word_t  io_rdata,
  output regno_t      mem_wregno,  // For the decode hazard check
  output logic        wb_we,
  output regno_t      wb_regno,
  output word_t       wb_data
);

  localparam word_t IO_BASE = `CPU_ADDR_HEX;  // Page holding all I/O registers

  word_t dmem [0:(1 << `CPU_DMEM_ADDR_BITS)-1];
  logic [`CPU_DMEM_ADDR_BITS-1:0] dmem_idx;
  logic  is_io;
  word_t load_val;

  assign dmem_idx = xm.result[`CPU_DMEM_ADDR_BITS+1:2];  // Upper bits alias
  assign is_io    = (xm.result[31:12] == IO_BASE[31:12]);

  assign io_addr  = xm.result;
  assign io_wdata = xm.store_val;
  assign io_we    = xm.wr_mem && is_io;

  assign load_val = is_io ? io_rdata : dmem[dmem_idx];

  always_ff @(posedge clk)
  begin
    if (xm.wr_mem && !is_io)
      dmem[dmem_idx] <= xm.store_val;
  end

  // Memory latch, feeds the register file directly
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_we    <= 1'b0;
      wb_regno <= '0;
    end
    else
    begin
      wb_we    <= xm.wr_reg && (xm.wregno != '0);  // R0 is never written
      wb_regno <= xm.wregno;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_data <= xm.rd_mem ? load_val : xm.result;
  end

  assign mem_wregno = wb_regno;

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire regno_t rd_a,
  input  wire regno_t rd_b,
  output word_t       val_a,
  output word_t       val_b,
  input  wire         wb_we,     // Never set for R0
  input  wire regno_t wb_regno,
  input  wire word_t  wb_data
);

  word_t regs [0:(1 << `CPU_REGNO_BITS)-1];

  // Write-through so decode sees the value landing this cycle
  assign val_a = (wb_we && (wb_regno == rd_a)) ? wb_data : regs[rd_a];
  assign val_b = (wb_we && (wb_regno == rd_b)) ? wb_data : regs[rd_b];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < (1 << `CPU_REGNO_BITS); i++)
        regs[i] <= '0;
    end
    else if (wb_we)
      regs[wb_regno] <= wb_data;
  end

endmodule

`default_nettype wire

//--- verilog/stage_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Decode latch contents, consumed by execute
interface dx_if import cpu_pkg::*; ();
  op1_e   op1;
  op2_e   op2;
  ctrl_t  ctrl;
  word_t  val_a;   // Rs value
  word_t  val_b;   // Rt value
  word_t  imm;     // Sign-extended
  word_t  pc;      // Address after the instruction
  regno_t wregno;  // 0 when nothing is written

  modport decode (
    output op1, op2, ctrl, val_a, val_b, imm, pc, wregno
  );
  modport execute (
    input  op1, op2, ctrl, val_a, val_b, imm, pc, wregno
  );
endinterface

// Execute latch contents, consumed by memory
interface xm_if import cpu_pkg::*; ();
  word_t  result;     // ALU value, memory address or JAL link
  word_t  store_val;  // Rt for SW
  regno_t wregno;
  logic   rd_mem;
  logic   wr_mem;
  logic   wr_reg;

  modport execute (
    output result, store_val, wregno, rd_mem, wr_mem, wr_reg
  );
  modport memory (
    input  result, store_val, wregno, rd_mem, wr_mem, wr_reg
  );
endinterface

`default_nettype wire
